//--- Makefile
SIM_BIN = cpc_rom_loader_sim

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f cpc_rom_loader.f \
		--top-module cpc_rom_loader_tb -o $(SIM_BIN)
	out="$$(./obj_dir/$(SIM_BIN))"; echo "$$out"; \
		echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

//--- boot_writer/boot_writer.sv
// Boot download memory writer
`timescale 1ns/1ns

module boot_writer #(
	parameter logic [7:0] ROM_INDEX = 8'd0,
	parameter logic [7:0] EXP_INDEX = 8'd3
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,
	input  logic [7:0]                  ioctl_index,
	input  cpc_loader_pkg::ioctl_addr_t ioctl_addr,
	input  logic [7:0]                  ioctl_data,
	input  logic                        model_664,
	input  cpc_loader_pkg::page_t       slot_page,
	input  cpc_loader_pkg::bank_t       slot_bank,
	input  logic                        slot_valid,
	input  cpc_loader_pkg::page_t       exp_page,
	output logic                        boot_wr,
	output cpc_loader_pkg::boot_addr_t  boot_addr,
	output cpc_loader_pkg::bank_t       boot_bank,
	output logic [7:0]                  boot_data,
	output cpc_loader_pkg::rom_map_t    rom_map,
	output logic                        system_hold
);
	import cpc_loader_pkg::*;

	load_kind_e load_kind;
	logic       download_q;
	logic       model_q;
	logic       exp_model;
	logic       accept;
	page_t      cmd_page;
	bank_t      cmd_bank;

	always_comb begin
		load_kind = LOAD_NONE;
		if (ioctl_download) begin
			if (ioctl_index == ROM_INDEX)
				load_kind = LOAD_SYSTEM;
			else if (ioctl_index == EXP_INDEX)
				load_kind = LOAD_EXPANSION;
		end
	end

	// Model taken at the start of the download, bypassed in that cycle
	assign exp_model = (ioctl_download & ~download_q) ? model_664 : model_q;

	//////////////////////////////////////////////////////////////////////
	// Write command

	always_comb begin
		accept   = 1'b0;
		cmd_page = slot_page;
		cmd_bank = slot_bank;

		case (load_kind)
			LOAD_SYSTEM: accept = ioctl_wr & slot_valid;
			LOAD_EXPANSION: begin
				accept        = ioctl_wr;
				cmd_page[8]   = exp_page[8];
				cmd_page[7:0] = exp_page[7:0] + ioctl_addr[21:14];	// Wraps in 8 bits
				cmd_bank      = {1'b0, exp_model};
			end
			default: accept = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			boot_addr <= {cmd_page, ioctl_addr[13:0]};
			boot_bank <= cmd_bank;
			boot_data <= ioctl_data;
		end
		if (ioctl_download && !download_q)
			model_q <= model_664;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			boot_wr     <= 1'b0;
			download_q  <= 1'b0;
			system_hold <= 1'b0;
			rom_map     <= '0;
		end else begin
			boot_wr     <= accept;
			download_q  <= ioctl_download;
			system_hold <= (load_kind != LOAD_NONE);	// Machine stays in reset
			if (accept && cmd_page[8])
				rom_map[cmd_page[7:0]] <= 1'b1;	// Slot now holds a ROM
		end
	end

	// Every command comes from a host write inside a ROM download
	a_wr_in_hold: assert property (@(posedge clk_sys) disable iff (reset)
		boot_wr |-> system_hold && $past(ioctl_wr));

endmodule

//--- common/cpc_loader_pkg.sv
// CPC ROM loader definitions
package cpc_loader_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths

	localparam int IOCTL_ADDR_W = 25;	// Host download byte address
	localparam int BOOT_ADDR_W  = 23;	// Byte address inside one 8 MB bank
	localparam int PAGE_W       = 9;	// 16 KB page number
	localparam int BANK_W       = 2;
	localparam int ROM_SLOTS    = 256;	// Upper-half ROM slots
	localparam int EXT_W        = 16;	// Two ASCII characters

	//////////////////////////////////////////////////////////////////////
	// Types

	typedef logic [IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [BOOT_ADDR_W-1:0]  boot_addr_t;

	// Bit 8 picks the upper half of the bank, which holds expansion ROMs
	typedef logic [PAGE_W-1:0]       page_t;
	typedef logic [BANK_W-1:0]       bank_t;

	// One bit per upper-half slot that has received data
	typedef logic [ROM_SLOTS-1:0]    rom_map_t;

	// First character of the extension sits in the high byte
	typedef logic [EXT_W-1:0]        ext_chars_t;

	//////////////////////////////////////////////////////////////////////
	// Page numbers

	// Lower half of a bank
	//   000       OS ROM
	//   001-0FE   RAM pages
	//   0FF       MF2 ROM
	// Upper half
	//   100-1FF   expansion ROM slots 00-FF
	localparam page_t PAGE_OS     = 9'h000;
	localparam page_t PAGE_BASIC  = 9'h100;	// Slot 0
	localparam page_t PAGE_AMSDOS = 9'h107;	// Slot 7
	localparam page_t PAGE_MF2    = 9'h0FF;

	// Unused slot, target of a malformed extension
	localparam page_t PAGE_BAD    = 9'h1EE;

	// Base for the tail of a "Z0" image
	// Low byte wraps to 00 once the region offset of 1 is added
	localparam page_t PAGE_COMBO_TAIL = 9'h1FF;

	//////////////////////////////////////////////////////////////////////
	// Download classes

	typedef enum logic [1:0] {
		LOAD_NONE,
		LOAD_SYSTEM,		// OS, BASIC, AMSDOS and MF2 image
		LOAD_EXPANSION		// Single ROM or a run of ROMs
	} load_kind_e;

endpackage

//--- cpc_rom_loader.f
common/cpc_loader_pkg.sv
design/rom_slot_map.sv
expansion_page/expansion_page_decoder.sv
boot_writer/boot_writer.sv
design/cpc_rom_loader.sv
testbench/cpc_rom_loader_tb.sv

//--- design/cpc_rom_loader.sv
// CPC boot ROM loader top
`timescale 1ns/1ns

module cpc_rom_loader #(
	parameter logic [7:0] ROM_INDEX = 8'd0,	// System ROM image
	parameter logic [7:0] EXP_INDEX = 8'd3	// Expansion ROM file
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        ioctl_download,
	input  logic [7:0]                  ioctl_index,
	input  logic                        ioctl_wr,
	input  cpc_loader_pkg::ioctl_addr_t ioctl_addr,
	input  logic [7:0]                  ioctl_data,
	input  cpc_loader_pkg::ext_chars_t  ioctl_file_ext,
	input  logic                        model_664,
	output logic                        boot_wr,
	output cpc_loader_pkg::boot_addr_t  boot_addr,
	output cpc_loader_pkg::bank_t       boot_bank,
	output logic [7:0]                  boot_data,
	output cpc_loader_pkg::rom_map_t    rom_map,
	output logic                        system_hold
);
	import cpc_loader_pkg::*;

	page_t slot_page;
	bank_t slot_bank;
	logic  slot_valid;
	page_t exp_page;

	rom_slot_map rom_slot_map_inst (
		.ioctl_addr (ioctl_addr),
		.slot_page  (slot_page),
		.slot_bank  (slot_bank),
		.slot_valid (slot_valid)
	);

	expansion_page_decoder expansion_page_decoder_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_file_ext (ioctl_file_ext),
		.exp_page       (exp_page)
	);

	boot_writer #(
		.ROM_INDEX (ROM_INDEX),
		.EXP_INDEX (EXP_INDEX)
	) boot_writer_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.model_664      (model_664),
		.slot_page      (slot_page),
		.slot_bank      (slot_bank),
		.slot_valid     (slot_valid),
		.exp_page       (exp_page),
		.boot_wr        (boot_wr),
		.boot_addr      (boot_addr),
		.boot_bank      (boot_bank),
		.boot_data      (boot_data),
		.rom_map        (rom_map),
		.system_hold    (system_hold)
	);

endmodule

//--- design/rom_slot_map.sv
// System ROM slot mapper
`timescale 1ns/1ns

module rom_slot_map (
	input  cpc_loader_pkg::ioctl_addr_t ioctl_addr,
	output cpc_loader_pkg::page_t       slot_page,
	output cpc_loader_pkg::bank_t       slot_bank,
	output logic                        slot_valid
);
	import cpc_loader_pkg::*;

	logic [IOCTL_ADDR_W-15:0] region;	// 16 KB region of the image

	assign region = ioctl_addr[IOCTL_ADDR_W-1:14];

	// Image layout is two sets of four ROMs
	// First set for the 6128 in bank 0, second for the 664 in bank 1
	always_comb begin
		slot_page  = '1;
		slot_bank  = '0;
		slot_valid = 1'b1;

		case (region)
			11'd0, 11'd4: slot_page = PAGE_OS;
			11'd1, 11'd5: slot_page = PAGE_BASIC;
			11'd2, 11'd6: slot_page = PAGE_AMSDOS;
			11'd3, 11'd7: slot_page = PAGE_MF2;
			default:      slot_valid = 1'b0;	// Past the end of the image
		endcase

		case (region)
			11'd4, 11'd5, 11'd6, 11'd7: slot_bank = 2'd1;
			default:                    slot_bank = 2'd0;
		endcase
	end

	// Only the two model banks are ever a target
	always_comb begin
		assert (slot_bank <= 2'd1)
			else $error("rom_slot_map: bank %0d out of range", slot_bank);
	end

endmodule

//--- expansion_page/expansion_page_decoder.sv
// Expansion ROM start page decoder
`timescale 1ns/1ns

module expansion_page_decoder (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,
	input  cpc_loader_pkg::ioctl_addr_t ioctl_addr,
	input  cpc_loader_pkg::ext_chars_t  ioctl_file_ext,
	output cpc_loader_pkg::page_t       exp_page
);
	import cpc_loader_pkg::*;

	localparam ext_chars_t EXT_PAGE_ZERO = "ZZ";	// Single ROM into page 0
	localparam ext_chars_t EXT_COMBO     = "Z0";	// Page 0, then slots from 0

	logic       download_q;
	logic       wr_q;
	logic       combo;
	logic       download_start;
	logic       wr_fall;
	logic [4:0] hi_nibble;	// {valid, value}
	logic [4:0] lo_nibble;
	page_t      parsed_page;

	// Uppercase hex digit to nibble, bit 4 flags a valid digit
	function automatic logic [4:0] hex_nibble(input logic [7:0] ch);
		logic [4:0] result;
		result = '0;
		if (ch >= "0" && ch <= "9")
			result = {1'b1, ch[3:0]};
		else if (ch >= "A" && ch <= "F")
			result = {1'b1, ch[3:0] + 4'd9};
		return result;
	endfunction

	assign download_start = ioctl_download & ~download_q;
	assign wr_fall        = wr_q & ~ioctl_wr;	// Write just completed

	assign hi_nibble = hex_nibble(ioctl_file_ext[15:8]);
	assign lo_nibble = hex_nibble(ioctl_file_ext[7:0]);

	// A bad character keeps its nibble of PAGE_BAD
	always_comb begin
		parsed_page      = PAGE_BAD;
		if (hi_nibble[4])
			parsed_page[7:4] = hi_nibble[3:0];
		if (lo_nibble[4])
			parsed_page[3:0] = lo_nibble[3:0];
		if (ioctl_file_ext == EXT_PAGE_ZERO || ioctl_file_ext == EXT_COMBO)
			parsed_page = PAGE_OS;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			wr_q       <= 1'b0;
			combo      <= 1'b0;
			exp_page   <= PAGE_BAD;
		end else begin
			download_q <= ioctl_download;
			wr_q       <= ioctl_wr;

			if (download_start) begin
				exp_page <= parsed_page;
				combo    <= (ioctl_file_ext == EXT_COMBO);
			end else if (wr_fall && combo && &ioctl_addr[13:0]) begin
				// Last byte of the page 0 part, rest goes to the slots
				exp_page <= PAGE_COMBO_TAIL;
				combo    <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	a_combo_only_z0: assert property (@(posedge clk_sys) disable iff (reset)
		download_start && ioctl_file_ext != EXT_COMBO |=> !combo);

	a_page_moves_on_edge: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(exp_page) |-> $past(download_start || wr_fall));

endmodule

//--- testbench/cpc_rom_loader_tb.sv
// CPC ROM loader testbench
`timescale 1ns/1ns

module cpc_rom_loader_tb;
	import cpc_loader_pkg::*;

	localparam logic [7:0] ROM_INDEX = 8'd0;
	localparam logic [7:0] EXP_INDEX = 8'd3;
	localparam int         TIMEOUT   = 20;	// Clock cycles per wait

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	logic [7:0]  ioctl_data;
	ext_chars_t  ioctl_file_ext;
	logic        model_664;
	logic        boot_wr;
	boot_addr_t  boot_addr;
	bank_t       boot_bank;
	logic [7:0]  boot_data;
	rom_map_t    rom_map;
	logic        system_hold;

	integer      seed = 32'h6138f4d2;
	ext_chars_t  cur_ext;	// Extension of the running download
	bank_t       cur_bank;	// Bank expected for expansion writes
	rom_map_t    map_model;

	cpc_rom_loader #(
		.ROM_INDEX (ROM_INDEX),
		.EXP_INDEX (EXP_INDEX)
	) cpc_rom_loader_inst (
		.clk_sys (clk_sys), .reset (reset), .ioctl_download (ioctl_download),
		.ioctl_index (ioctl_index), .ioctl_wr (ioctl_wr), .ioctl_addr (ioctl_addr),
		.ioctl_data (ioctl_data), .ioctl_file_ext (ioctl_file_ext), .model_664 (model_664),
		.boot_wr (boot_wr), .boot_addr (boot_addr), .boot_bank (boot_bank),
		.boot_data (boot_data), .rom_map (rom_map), .system_hold (system_hold)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	task automatic fail_run(string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_addr(string name, boot_addr_t got, boot_addr_t want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want));
	endtask

	task automatic check_bank(string name, bank_t got, bank_t want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want));
	endtask

	task automatic check_data(string name, logic [7:0] got, logic [7:0] want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want));
	endtask

	task automatic check_map(string name, rom_map_t got, rom_map_t want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want));
	endtask

	task automatic check_hold(string name, logic got, logic want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t ns: %s got %b expected %b", $time, name, got, want));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Expected results

	// Image holds OS, BASIC, AMSDOS, MF2 for each model
	function automatic page_t system_page(int region);
		page_t page;
		case (region % 4)
			0:       page = PAGE_OS;
			1:       page = PAGE_BASIC;
			2:       page = PAGE_AMSDOS;
			default: page = PAGE_MF2;
		endcase
		return page;
	endfunction

	function automatic page_t ext_start_page(ext_chars_t ext);
		page_t      page;
		logic [7:0] ch;
		page = PAGE_BAD;
		if (ext == "ZZ" || ext == "Z0")
			return PAGE_OS;
		for (int i = 0; i < 2; i++) begin
			ch = ext[15-8*i -: 8];
			if (ch >= "0" && ch <= "9")
				page[7-4*i -: 4] = 4'(ch - "0");
			else if (ch >= "A" && ch <= "F")
				page[7-4*i -: 4] = 4'(ch - "A" + 8'd10);
		end
		return page;
	endfunction

	function automatic boot_addr_t expected_addr(load_kind_e kind, ioctl_addr_t addr);
		page_t      page;
		page_t      start;
		logic [7:0] region;
		region = addr[21:14];
		start  = ext_start_page(cur_ext);
		if (kind == LOAD_SYSTEM)
			page = system_page(int'(addr[24:14]));
		else if (cur_ext == "Z0" && region != 8'd0)
			page = {1'b1, region - 8'd1};	// Tail runs from slot 0
		else
			page = {start[8], start[7:0] + region};
		return {page, addr[13:0]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Download driver

	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		#2 reset = 1'b0;
		map_model = '0;
	endtask

	task automatic begin_download(logic [7:0] index, ext_chars_t ext, logic model);
		ioctl_index    = index;
		ioctl_file_ext = ext;
		model_664      = model;
		ioctl_download = 1'b1;
		cur_ext        = ext;
		cur_bank       = {1'b0, model};
		repeat (2) @(posedge clk_sys);	// Start page settles
		#2;
	endtask

	task automatic end_download();
		int waited;
		ioctl_download = 1'b0;
		waited = 0;
		@(negedge clk_sys);
		while (system_hold && waited < TIMEOUT) begin
			waited++;
			@(negedge clk_sys);
		end
		check_hold("system_hold", system_hold, 1'b0);
		@(posedge clk_sys);
		#2;
	endtask

	// One byte, then one idle cycle
	task automatic write_byte(load_kind_e kind, ioctl_addr_t addr);
		logic       accepted;
		logic [7:0] data;
		boot_addr_t want_addr;
		bank_t      want_bank;
		int         waited;
		accepted   = (kind == LOAD_EXPANSION) || (addr[24:14] < 11'd8);
		want_addr  = expected_addr(kind, addr);
		want_bank  = (kind == LOAD_SYSTEM) ? ((addr[24:14] >= 11'd4) ? 2'd1 : 2'd0) : cur_bank;
		data       = 8'($random(seed));
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		@(posedge clk_sys);
		#2 ioctl_wr = 1'b0;
		waited = 0;
		@(negedge clk_sys);
		while (!boot_wr && waited < TIMEOUT) begin
			waited++;
			@(negedge clk_sys);
		end
		if (accepted) begin
			if (!boot_wr)
				fail_run($sformatf("timeout at %0t ns waiting for boot_wr", $time));
			if (want_addr[22])
				map_model[want_addr[21:14]] = 1'b1;
			check_addr("boot_addr", boot_addr, want_addr);
			check_bank("boot_bank", boot_bank, want_bank);
			check_data("boot_data", boot_data, data);
			check_hold("system_hold", system_hold, 1'b1);
		end else if (boot_wr) begin
			fail_run($sformatf("boot_wr at %0t ns for a byte past the ROM image", $time));
		end
		check_map("rom_map", rom_map, map_model);
		@(posedge clk_sys);
		#2;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic system_rom_download();
		begin_download(ROM_INDEX, "RO", 1'b0);
		for (int r = 0; r < 9; r++)
			write_byte(LOAD_SYSTEM, ioctl_addr_t'(r * 16384 + r * 37));	// Region 8 is dropped
		end_download();
	endtask

	task automatic valid_extension_download();
		rom_map_t want;
		want = '0;
		want[8'h1A] = 1'b1;
		want[8'h1B] = 1'b1;
		begin_download(EXP_INDEX, "1A", 1'b0);
		write_byte(LOAD_EXPANSION, 25'd0);
		write_byte(LOAD_EXPANSION, 25'd16384);
		end_download();
		check_map("rom_map", rom_map, want);
	endtask

	task automatic malformed_extension_download();
		begin_download(EXP_INDEX, "QQ", 1'b0);
		write_byte(LOAD_EXPANSION, 25'h0123);
		end_download();
		begin_download(EXP_INDEX, "3Q", 1'b0);
		write_byte(LOAD_EXPANSION, 25'h0456);
		end_download();
	endtask

	task automatic page_zero_extensions();
		begin_download(EXP_INDEX, "ZZ", 1'b0);
		write_byte(LOAD_EXPANSION, 25'h0010);
		end_download();
		check_map("rom_map", rom_map, '0);
		begin_download(EXP_INDEX, "Z0", 1'b0);
		for (int i = 0; i < 16384; i++)
			write_byte(LOAD_EXPANSION, ioctl_addr_t'(i));
		write_byte(LOAD_EXPANSION, 25'd16384);
		end_download();
		check_map("rom_map", rom_map, rom_map_t'(1));
	endtask

	task automatic bank_and_hold();
		begin_download(EXP_INDEX, "05", 1'b1);
		model_664 = 1'b0;	// Bank keeps the value from the start
		write_byte(LOAD_EXPANSION, 25'h0200);
		end_download();
		begin_download(EXP_INDEX, "06", 1'b0);
		model_664 = 1'b1;
		write_byte(LOAD_EXPANSION, 25'h0300);
		end_download();
	endtask

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = 8'd0;
		ioctl_file_ext = '0;
		model_664      = 1'b0;
		cur_ext        = '0;
		cur_bank       = '0;
		map_model      = '0;

		apply_reset();
		system_rom_download();
		apply_reset();
		valid_extension_download();
		apply_reset();
		malformed_extension_download();
		apply_reset();
		page_zero_extensions();
		apply_reset();
		bank_and_hold();

		$display("Finished with no errors");
		$finish;
	end

endmodule
